// File: lsab_patterns.mem
// op_q_tag_anc_care_data_expect, op 1 write 2 read 0 idle f end
// care is a queue mask, expect is the word a read returns
1_1_0_0_0_1111aaaa_00000000
1_1_0_0_0_2222bbbb_00000000
2_1_0_0_0_00000000_1111aaaa
2_1_0_0_0_00000000_2222bbbb
1_0_1_1_0_30000001_00000000
1_0_1_2_0_30000002_00000000
1_0_1_3_0_30000003_00000000
1_0_1_4_0_30000004_00000000
2_0_0_0_1_00000000_30000001
0_0_0_0_0_00000000_00000000
2_0_0_0_1_00000000_30000002
0_0_0_0_0_00000000_00000000
2_0_0_0_0_00000000_30000003
2_0_0_0_1_00000000_30000004
0_0_0_0_0_00000000_00000000
f_0_0_0_0_00000000_00000000

// File: project.f
+incdir+.
lsab_pkg.sv
lsab_sram.sv
lsab_occupancy.sv
lsab_stop_fsm.sv
lsab_queue.sv
lsab_ram_port.sv
lsab_top.sv
lsab_assertions.sv
tb_lsab.sv

// File: Bender.yml
package:
  name: lsab

export_include_dirs:
  - .

sources:
  - lsab_pkg.sv
  - lsab_sram.sv
  - lsab_occupancy.sv
  - lsab_stop_fsm.sv
  - lsab_queue.sv
  - lsab_ram_port.sv
  - lsab_top.sv
  - target: test
    files:
      - lsab_assertions.sv
      - tb_lsab.sv

// File: tb_lsab.sv
`timescale 1ns/10ps
`include "lsab_config.svh"

module tb_lsab import lsab_pkg::*; ();

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_RUN   = 2'd1;
  localparam logic [1:0] S_PAUSE = 2'd2;

  logic                       CLK, RST, read, write, int_in, out_valid;
  qsel_t                      read_fifo, write_fifo;
  word_t                      in_data, out_data;
  ancill_t                    ancill_in;
  logic    [`LSAB_QUEUES-1:0] care_int, empty, stop, int_out;
  ancill_t [`LSAB_QUEUES-1:0] ancill_out;

  // reference model, one ring per queue
  word_t       m_data [4][64];
  logic [3:0]  m_mark [4][64]; // recorded flag then side bits
  int          m_len [4], m_rp [4], m_wp [4], m_nmk [4];
  logic [1:0]  m_st [4];
  ancill_t     m_anc [4];
  word_t       exp_q [$];
  logic [83:0] pat [0:63];
  logic [31:0] lfsr;
  int          errs, n_checks, n_tests, err_mark;

  lsab_top u_dut (
    .CLK        (CLK),
    .RST        (RST),
    .read       (read),
    .write      (write),
    .read_fifo  (read_fifo),
    .write_fifo (write_fifo),
    .in_data    (in_data),
    .int_in     (int_in),
    .ancill_in  (ancill_in),
    .care_int   (care_int),
    .out_data   (out_data),
    .out_valid  (out_valid),
    .empty      (empty),
    .stop       (stop),
    .int_out    (int_out),
    .ancill_out (ancill_out)
  );

  bind lsab_top lsab_assertions u_assertions (
    .CLK       (CLK),
    .RST       (RST),
    .empty     (empty),
    .stop      (stop),
    .int_out   (int_out),
    .ram_re    (ram_re),
    .out_valid (out_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1; // taps 32 22 2 1
    end
    return v;
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      errs++;
    end
  endtask

  // one clock: check what settled, drive the next inputs, advance the model
  task automatic step(input logic rd, input qsel_t rq, input logic wr, input qsel_t wq,
                      input word_t d, input logic tag, input ancill_t anc,
                      input logic [3:0] care, input logic from_file, input word_t exp_w);
    logic       rd_i, wr_i, hit;
    logic [3:0] head;
    @(negedge CLK);
    for (int i = 0; i < 4; i++) begin
      check($sformatf("q%0d empty/stop/int/ancill", i),
            64'({empty[i], stop[i], int_out[i], ancill_out[i]}),
            64'({m_st[i] == S_IDLE, m_st[i] != S_RUN, m_st[i] == S_PAUSE, m_anc[i]}));
    end
    if (out_valid) begin
      if (exp_q.size() == 0) begin
        check("out_valid", 64'(1), 64'(0));
      end else begin
        check("out_data", 64'(out_data), 64'(exp_q.pop_front()));
      end
    end
    read       = rd;
    read_fifo  = rq;
    write      = wr;
    write_fifo = wq;
    in_data    = d;
    int_in     = tag;
    ancill_in  = anc;
    care_int   = care;
    for (int i = 0; i < 4; i++) begin
      rd_i = rd && int'(rq) == i && m_st[i] == S_RUN;
      wr_i = wr && int'(wq) == i && m_len[i] < 64;
      head = m_mark[i][m_rp[i]];
      hit  = rd_i && head[3];
      if (rd_i) begin
        exp_q.push_back(from_file ? exp_w : m_data[i][m_rp[i]]);
        m_rp[i] = (m_rp[i] + 1) % 64;
      end
      if (wr_i) begin
        m_data[i][m_wp[i]] = d;
        m_mark[i][m_wp[i]] = {tag && m_nmk[i] < 3, anc}; // three pending at most
        if (tag && m_nmk[i] < 3) begin
          m_nmk[i]++;
        end
        m_wp[i] = (m_wp[i] + 1) % 64;
      end
      if (hit) begin
        m_anc[i] = head[2:0];
        m_nmk[i]--;
      end
      m_len[i] = m_len[i] + int'(wr_i) - int'(rd_i);
      // interrupt outranks going empty
      m_st[i] = (hit && care[i]) ? S_PAUSE : (m_len[i] == 0) ? S_IDLE : S_RUN;
    end
  endtask

  task automatic idle();
    step(1'b0, '0, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic wait_reads();
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < 8) begin
      idle();
      n++;
    end
    if (exp_q.size() > 0) begin
      $display("timeout: %0d read results still missing after %0d cycles", exp_q.size(), n);
      errs++;
    end
    repeat (2) idle(); // a stray out_valid from the last reads lands here
  endtask

  task automatic report_test(input string name);
    n_tests++;
    $display("test %-12s %s, %0d errors", name, (errs == err_mark) ? "ok" : "bad",
             errs - err_mark);
    err_mark = errs;
  endtask

  initial begin
    logic [31:0] r;
    word_t       d;
    RST        = 1'b0;
    read       = 1'b0;
    write      = 1'b0;
    read_fifo  = '0;
    write_fifo = '0;
    in_data    = '0;
    int_in     = 1'b0;
    ancill_in  = '0;
    care_int   = '0;
    lfsr       = 32'h9018;
    errs       = 0;
    n_checks   = 0;
    n_tests    = 0;
    err_mark   = 0;
    for (int i = 0; i < 4; i++) begin
      m_len[i] = 0;
      m_rp[i]  = 0;
      m_wp[i]  = 0;
      m_nmk[i] = 0;
      m_st[i]  = S_IDLE;
      m_anc[i] = '0;
    end
    $readmemh("lsab_patterns.mem", pat);
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;

    repeat (4) idle();
    report_test("reset");

    if ($isunknown(pat[0])) begin
      $display("pattern file lsab_patterns.mem could not be read");
      errs++;
    end
    for (int i = 0; i < 64 && pat[i][83:80] != 4'hf; i++) begin
      step(pat[i][83:80] == 4'h2, pat[i][77:76], pat[i][83:80] == 4'h1, pat[i][77:76],
           pat[i][63:32], pat[i][72], pat[i][70:68], pat[i][67:64], 1'b1, pat[i][31:0]);
    end
    wait_reads();
    report_test("patterns");

    // mixed traffic on all queues, no markers
    for (int n = 0; n < 400; n++) begin
      r = rand_bits(7);
      d = rand_bits(32);
      step(r[6], r[5:4], r[3] | r[2], r[1:0], d, 1'b0, '0, '0, 1'b0, '0);
    end
    for (int i = 0; i < 4; i++) begin
      for (int n = 0; n < 80 && m_len[i] > 0; n++) begin
        step(1'b1, qsel_t'(i), 1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0);
      end
    end
    wait_reads();
    report_test("interleave");

    // 65 writes to queue 2, the last is dropped
    for (int n = 0; n < 65; n++) begin
      d = rand_bits(32);
      step(1'b0, '0, 1'b1, 2'd2, d, 1'b0, '0, '0, 1'b0, '0);
    end
    for (int n = 0; n < 66; n++) begin
      step(1'b1, 2'd2, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0); // last two see stop
    end
    wait_reads();
    report_test("full_stop");

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, errs);
    if (errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: lsab_assertions.sv
`timescale 1ns/10ps
`include "lsab_config.svh"

module lsab_assertions (
  input logic                    CLK,
  input logic                    RST,
  input logic [`LSAB_QUEUES-1:0] empty,
  input logic [`LSAB_QUEUES-1:0] stop,
  input logic [`LSAB_QUEUES-1:0] int_out,
  input logic                    ram_re,
  input logic                    out_valid
);

  // an empty queue always holds off its reader
  empty_implies_stop: assert property (@(posedge CLK) disable iff (!RST)
    (empty & ~stop) == '0) else $error("empty is set without stop");

  int_implies_stop: assert property (@(posedge CLK) disable iff (!RST)
    (int_out & ~stop) == '0) else $error("int_out is set without stop");

  // data ram then output register
  read_latency: assert property (@(posedge CLK) disable iff (!RST)
    ram_re |-> ##2 out_valid) else $error("out_valid missing two cycles after a read");

  no_stray_valid: assert property (@(posedge CLK) disable iff (!RST)
    out_valid |-> $past(ram_re, 2)) else $error("out_valid with no read two cycles before");

endmodule

// File: lsab_top.sv
`timescale 1ns/10ps
`include "lsab_config.svh"

module lsab_top import lsab_pkg::*; (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         read,
  input  logic                         write,
  input  qsel_t                        read_fifo,
  input  qsel_t                        write_fifo,
  input  word_t                        in_data,
  input  logic                         int_in,
  input  ancill_t                      ancill_in,
  input  logic    [`LSAB_QUEUES-1:0]   care_int,
  output word_t                        out_data,
  output logic                         out_valid,
  output logic    [`LSAB_QUEUES-1:0]   empty,
  output logic    [`LSAB_QUEUES-1:0]   stop,
  output logic    [`LSAB_QUEUES-1:0]   int_out,
  output ancill_t [`LSAB_QUEUES-1:0]   ancill_out
);

  logic   [`LSAB_QUEUES-1:0] q_rd_go, q_wr_go;
  qaddr_t [`LSAB_QUEUES-1:0] q_rd_addr, q_wr_addr;

  ram_addr_t ram_raddr, ram_waddr;
  logic      ram_re, ram_we;
  word_t     ram_wdata, ram_rdata;

  for (genvar i = 0; i < `LSAB_QUEUES; i++) begin : g_queue
    lsab_queue #(.QID(qsel_t'(i))) u_queue (
      .CLK        (CLK),
      .RST        (RST),
      .read       (read),
      .write      (write),
      .read_fifo  (read_fifo),
      .write_fifo (write_fifo),
      .int_in     (int_in),
      .ancill_in  (ancill_in),
      .care_int   (care_int[i]),
      .rd_go      (q_rd_go[i]),
      .wr_go      (q_wr_go[i]),
      .rd_addr    (q_rd_addr[i]),
      .wr_addr    (q_wr_addr[i]),
      .empty      (empty[i]),
      .stop       (stop[i]),
      .int_out    (int_out[i]),
      .ancill_out (ancill_out[i])
    );
  end

  lsab_ram_port u_port (
    .CLK        (CLK),
    .RST        (RST),
    .read_fifo  (read_fifo),
    .write_fifo (write_fifo),
    .rd_go      (q_rd_go),
    .wr_go      (q_wr_go),
    .rd_addr    (q_rd_addr),
    .wr_addr    (q_wr_addr),
    .in_data    (in_data),
    .ram_raddr  (ram_raddr),
    .ram_waddr  (ram_waddr),
    .ram_re     (ram_re),
    .ram_we     (ram_we),
    .ram_wdata  (ram_wdata),
    .ram_rdata  (ram_rdata),
    .out_data   (out_data),
    .out_valid  (out_valid)
  );

  // all four queues share this 256-word block
  lsab_sram #(
    .DEPTH_BITS ($bits(ram_addr_t)),
    .payload_t  (word_t)
  ) u_data_ram (
    .CLK   (CLK),
    .raddr (ram_raddr),
    .re    (ram_re),
    .rdata (ram_rdata),
    .waddr (ram_waddr),
    .we    (ram_we),
    .wdata (ram_wdata)
  );

endmodule

// File: lsab_ram_port.sv
`timescale 1ns/10ps
`include "lsab_config.svh"

module lsab_ram_port import lsab_pkg::*; (
  input  logic                        CLK,
  input  logic                        RST,
  input  qsel_t                       read_fifo,
  input  qsel_t                       write_fifo,
  input  logic   [`LSAB_QUEUES-1:0]   rd_go,
  input  logic   [`LSAB_QUEUES-1:0]   wr_go,
  input  qaddr_t [`LSAB_QUEUES-1:0]   rd_addr,
  input  qaddr_t [`LSAB_QUEUES-1:0]   wr_addr,
  input  word_t                       in_data,
  output ram_addr_t                   ram_raddr,
  output ram_addr_t                   ram_waddr,
  output logic                        ram_re,
  output logic                        ram_we,
  output word_t                       ram_wdata,
  input  word_t                       ram_rdata,
  output word_t                       out_data,
  output logic                        out_valid
);

  logic re_q;

  // only the selected queue can raise its go line
  assign ram_raddr = ram_addr_t'{qsel: read_fifo, qaddr: rd_addr[read_fifo]};
  assign ram_re    = rd_go[read_fifo];

  assign ram_waddr = ram_addr_t'{qsel: write_fifo, qaddr: wr_addr[write_fifo]};
  assign ram_we    = wr_go[write_fifo];
  assign ram_wdata = in_data;

  // second stage of the two-cycle read
  always_ff @(posedge CLK) begin
    if (!RST) begin
      re_q      <= 1'b0;
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      re_q      <= ram_re;
      out_valid <= re_q;
      if (re_q) begin
        out_data <= ram_rdata;
      end
    end
  end

endmodule

// File: lsab_queue.sv
`timescale 1ns/10ps
`include "lsab_config.svh"

module lsab_queue import lsab_pkg::*; #(
  parameter qsel_t QID = '0
) (
  input  logic    CLK,
  input  logic    RST,
  input  logic    read,
  input  logic    write,
  input  qsel_t   read_fifo,
  input  qsel_t   write_fifo,
  input  logic    int_in,
  input  ancill_t ancill_in,
  input  logic    care_int,
  output logic    rd_go,
  output logic    wr_go,
  output qaddr_t  rd_addr,
  output qaddr_t  wr_addr,
  output logic    empty,
  output logic    stop,
  output logic    int_out,
  output ancill_t ancill_out
);

  logic full, will_empty, mark_hit;

  logic [`LSAB_MARK_BITS-1:0] mk_rptr, mk_rptr_nxt, mk_wptr;
  logic    mk_empty, mk_full, mk_we;
  marker_t mk_wdata, mk_rdata, mk_head;
  marker_t byp_data;
  logic    byp_q;

  assign wr_go = write && (write_fifo == QID) && !full;
  assign rd_go = read && (read_fifo == QID) && !stop;

  lsab_occupancy u_occ (
    .CLK        (CLK),
    .RST        (RST),
    .rd_go      (rd_go),
    .wr_go      (wr_go),
    .rd_addr    (rd_addr),
    .wr_addr    (wr_addr),
    .full       (full),
    .will_empty (will_empty)
  );

  lsab_stop_fsm u_fsm (
    .CLK        (CLK),
    .RST        (RST),
    .will_empty (will_empty),
    .mark_hit   (mark_hit),
    .care_int   (care_int),
    .stop       (stop),
    .empty      (empty),
    .int_out    (int_out)
  );

  // one slot kept free so full and empty differ
  assign mk_empty = (mk_rptr == mk_wptr);
  assign mk_full  = ((mk_wptr + 1'b1) == mk_rptr);
  assign mk_we    = int_in && wr_go && !mk_full;
  assign mk_wdata = marker_t'{addr: wr_addr, ancill: ancill_in};

  assign mk_rptr_nxt = mark_hit ? mk_rptr + 1'b1 : mk_rptr;

  // head is fetched every cycle from the next read pointer
  lsab_sram #(
    .DEPTH_BITS (`LSAB_MARK_BITS),
    .payload_t  (marker_t)
  ) u_mark (
    .CLK   (CLK),
    .raddr (mk_rptr_nxt),
    .re    (1'b1),
    .rdata (mk_rdata),
    .waddr (mk_wptr),
    .we    (mk_we),
    .wdata (mk_wdata)
  );

  // fresh marker landing on the head slot is not yet in rdata
  assign mk_head  = byp_q ? byp_data : mk_rdata;
  assign mark_hit = rd_go && !mk_empty && (mk_head.addr == rd_addr);

  always_ff @(posedge CLK) begin
    byp_data <= mk_wdata;
  end

  always_ff @(posedge CLK) begin
    if (!RST) begin
      mk_rptr    <= '0;
      mk_wptr    <= '0;
      byp_q      <= 1'b0;
      ancill_out <= '0;
    end else begin
      mk_rptr <= mk_rptr_nxt;
      byp_q   <= mk_we && (mk_wptr == mk_rptr_nxt);
      if (mk_we) begin
        mk_wptr <= mk_wptr + 1'b1;
      end
      if (mark_hit) begin
        ancill_out <= mk_head.ancill; // held until the next hit
      end
    end
  end

endmodule

// File: lsab_stop_fsm.sv
`timescale 1ns/10ps

module lsab_stop_fsm (
  input  logic CLK,
  input  logic RST,
  input  logic will_empty,
  input  logic mark_hit,
  input  logic care_int,
  output logic stop,
  output logic empty,
  output logic int_out
);

  typedef enum logic [1:0] {
    idle_empty,
    run,
    pause
  } state_t;

  state_t state, state_nxt;

  // an interrupt wins over going empty, so a tagged last word
  // still raises int_out; idle_empty follows one cycle later
  always_comb begin
    if (mark_hit && care_int) begin
      state_nxt = pause;
    end else if (will_empty) begin
      state_nxt = idle_empty;
    end else begin
      state_nxt = run; // pause lasts a single cycle
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST) begin
      state <= idle_empty;
    end else begin
      state <= state_nxt;
    end
  end

  // flags decoded straight from the state register
  assign stop    = (state != run);
  assign empty   = (state == idle_empty);
  assign int_out = (state == pause);

endmodule

// File: lsab_occupancy.sv
`timescale 1ns/10ps
`include "lsab_config.svh"

module lsab_occupancy import lsab_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  logic   rd_go,
  input  logic   wr_go,
  output qaddr_t rd_addr,
  output qaddr_t wr_addr,
  output logic   full,
  output logic   will_empty
);

  localparam int LW = `LSAB_DEPTH_BITS + 1; // must hold a count of 64

  localparam logic [LW-1:0] LEN_ZERO = '0;
  localparam logic [LW-1:0] LEN_ONE  = LW'(1);
  localparam logic [LW-1:0] LEN_TOP  = LW'(2**`LSAB_DEPTH_BITS);
  localparam logic [LW-1:0] LEN_NEAR = LW'(2**`LSAB_DEPTH_BITS - 1);

  logic [LW-1:0] len, len_nxt;
  logic          empty_q;
  logic          full_nxt;

  // only the four boundary transitions change the flags
  always_comb begin
    full_nxt   = full;
    will_empty = empty_q;
    case ({len, rd_go, wr_go})
      {LEN_TOP,  2'b10}: begin full_nxt = 1'b0; will_empty = 1'b0; end
      {LEN_NEAR, 2'b01}: begin full_nxt = 1'b1; will_empty = 1'b0; end
      {LEN_ONE,  2'b10}: begin full_nxt = 1'b0; will_empty = 1'b1; end
      {LEN_ZERO, 2'b01}: begin full_nxt = 1'b0; will_empty = 1'b0; end
      default: ;
    endcase
  end

  always_comb begin
    case ({rd_go, wr_go})
      2'b10:   len_nxt = len - 1'b1;
      2'b01:   len_nxt = len + 1'b1;
      default: len_nxt = len; // both or neither
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!RST) begin
      rd_addr <= '0;
      wr_addr <= '0;
      len     <= '0;
      full    <= 1'b0;
      empty_q <= 1'b1;
    end else begin
      len     <= len_nxt;
      full    <= full_nxt;
      empty_q <= will_empty;
      if (wr_go) begin
        wr_addr <= wr_addr + 1'b1;
      end
      if (rd_go) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

endmodule

// File: lsab_sram.sv
`timescale 1ns/10ps

module lsab_sram #(
  parameter int  DEPTH_BITS = 8,
  parameter type payload_t  = logic [31:0]
) (
  input  logic                  CLK,
  input  logic [DEPTH_BITS-1:0] raddr,
  input  logic                  re,
  output payload_t              rdata,
  input  logic [DEPTH_BITS-1:0] waddr,
  input  logic                  we,
  input  payload_t              wdata
);

  payload_t mem [2**DEPTH_BITS];

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read before write on a same-address collision
  always_ff @(posedge CLK) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

// File: lsab_pkg.sv
`include "lsab_config.svh"

package lsab_pkg;

  typedef logic [`LSAB_WORD_BITS-1:0]        word_t;
  typedef logic [$clog2(`LSAB_QUEUES)-1:0]   qsel_t;
  typedef logic [`LSAB_DEPTH_BITS-1:0]       qaddr_t;
  typedef logic [2:0]                        ancill_t;

  // tagged word position plus its side bits
  typedef struct packed {
    qaddr_t  addr;
    ancill_t ancill;
  } marker_t;

  // shared RAM address, queue in the upper bits
  typedef struct packed {
    qsel_t  qsel;
    qaddr_t qaddr;
  } ram_addr_t;

endpackage

// File: lsab_config.svh
`ifndef LSAB_CONFIG_SVH
`define LSAB_CONFIG_SVH

// number of independent queues
`define LSAB_QUEUES 4

// 64 entries per queue
`define LSAB_DEPTH_BITS 6

// marker store, 4 slots with 3 usable
`define LSAB_MARK_BITS 2

`define LSAB_WORD_BITS 32

`endif
